/* src/rv32_isa_pkg.sv */
////////////////////////////////////////
// RV32I base encodings only, XLEN fixed at 32
// Immediates are sign-extended to XLEN
////////////////////////////////////////

package rv32_isa_pkg;

    localparam int XLEN = 32;
    localparam int INSTR_W = 32;
    localparam int OPCODE_W = 7;
    localparam int FN3_W = 3;
    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [FN3_W-1:0] fn3_t;

    // Major opcodes kept by the decode stage
    typedef enum logic [OPCODE_W-1:0] {
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        ARITH_IMM = 7'b0010011,
        ARITH     = 7'b0110011
    } opcode_t;

    // Unsigned branch compares
    localparam fn3_t BLTU_FN3 = 3'b110;
    localparam fn3_t BGEU_FN3 = 3'b111;

    ////////////////////////////////////////
    // Field and immediate extraction

    function automatic opcode_t get_opcode(input logic [INSTR_W-1:0] instr);
        return opcode_t'(instr[OPCODE_W-1:0]);
    endfunction

    function automatic fn3_t get_fn3(input logic [INSTR_W-1:0] instr);
        return instr[14:12];
    endfunction

    function automatic logic [XLEN-1:0] imm_i(input logic [INSTR_W-1:0] instr);
        return {{(XLEN-12){instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] imm_s(input logic [INSTR_W-1:0] instr);
        return {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    endfunction

    // Bit 0 of branch and jump offsets is always zero
    function automatic logic [XLEN-1:0] imm_b(input logic [INSTR_W-1:0] instr);
        return {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_u(input logic [INSTR_W-1:0] instr);
        return {instr[31:12], 12'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_j(input logic [INSTR_W-1:0] instr);
        return {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

endpackage

/* src/issue_pkg.sv */
////////////////////////////////////////
// Three units only: ALU, load-store, branch
////////////////////////////////////////

package issue_pkg;

    import rv32_isa_pkg::*;

    ////////////////////////////////////////
    // Unit indexing

    typedef enum logic [1:0] {
        ALU_UNIT    = 2'd0,
        LS_UNIT     = 2'd1,
        BRANCH_UNIT = 2'd2
    } unit_e;

    localparam int NUM_UNITS = 3;

    typedef logic [NUM_UNITS-1:0] unit_mask_t;

    ////////////////////////////////////////
    // Fetch and register file

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instruction;
    } fetch_packet_t;

    typedef struct packed {
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
    } rf_read_req_t;

    // Conflict means the register is still pending a write
    typedef struct packed {
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic rs1_conflict;
        logic rs2_conflict;
    } rf_read_rsp_t;

    typedef struct packed {
        unit_mask_t unit_req;
        logic uses_rs1;
        logic uses_rs2;
        logic legal;
    } decoded_t;

    ////////////////////////////////////////
    // Unit payloads

    // Operands carry one extra sign bit for signed/unsigned compares
    typedef struct packed {
        logic [XLEN:0] in1;
        logic [XLEN:0] in2;
        fn3_t fn3;
        logic alt;
        reg_addr_t rd_addr;
    } alu_inputs_t;

    typedef struct packed {
        logic [XLEN-1:0] address;
        logic [XLEN-1:0] store_data;
        fn3_t fn3;
        logic is_load;
        logic is_store;
        reg_addr_t rd_addr;
    } ls_inputs_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target_offset;
        fn3_t fn3;
        logic use_signed;
        logic jal;
        logic jalr;
    } branch_inputs_t;

endpackage

/* src/instr_classifier.sv */
////////////////////////////////////////
// Combinational, no check of valid
// FENCE, SYSTEM and M-extension ops are illegal
////////////////////////////////////////

`timescale 1ns/1ps

module instr_classifier (
    input  issue_pkg::fetch_packet_t fetch,
    output issue_pkg::decoded_t      decoded
);

    import rv32_isa_pkg::*;
    import issue_pkg::*;

    opcode_t opcode;
    logic    mul_div_bit;

    assign opcode = get_opcode(fetch.instruction);
    assign mul_div_bit = fetch.instruction[25];

    always_comb begin
        decoded = '0;
        case (opcode)
            LUI, AUIPC: begin
                decoded.unit_req[ALU_UNIT] = 1'b1;
                decoded.legal = 1'b1;
            end
            ARITH_IMM: begin
                decoded.unit_req[ALU_UNIT] = 1'b1;
                decoded.uses_rs1 = 1'b1;
                decoded.legal = 1'b1;
            end
            // Bit 25 selects MUL/DIV, which is not supported
            ARITH: begin
                decoded.unit_req[ALU_UNIT] = ~mul_div_bit;
                decoded.uses_rs1 = 1'b1;
                decoded.uses_rs2 = 1'b1;
                decoded.legal = ~mul_div_bit;
            end
            // Link value goes through the ALU
            JAL: begin
                decoded.unit_req[ALU_UNIT] = 1'b1;
                decoded.unit_req[BRANCH_UNIT] = 1'b1;
                decoded.legal = 1'b1;
            end
            JALR: begin
                decoded.unit_req[ALU_UNIT] = 1'b1;
                decoded.unit_req[BRANCH_UNIT] = 1'b1;
                decoded.uses_rs1 = 1'b1;
                decoded.legal = 1'b1;
            end
            BRANCH: begin
                decoded.unit_req[BRANCH_UNIT] = 1'b1;
                decoded.uses_rs1 = 1'b1;
                decoded.uses_rs2 = 1'b1;
                decoded.legal = 1'b1;
            end
            LOAD: begin
                decoded.unit_req[LS_UNIT] = 1'b1;
                decoded.uses_rs1 = 1'b1;
                decoded.legal = 1'b1;
            end
            STORE: begin
                decoded.unit_req[LS_UNIT] = 1'b1;
                decoded.uses_rs1 = 1'b1;
                decoded.uses_rs2 = 1'b1;
                decoded.legal = 1'b1;
            end
            default: begin
                decoded = '0;
            end
        endcase
    end

endmodule

/* src/issue_control.sv */
////////////////////////////////////////
// Issue is all-or-nothing across requested units
// Illegal report lags the pop by one cycle
////////////////////////////////////////

`timescale 1ns/1ps

module issue_control (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetch_valid,
    input  logic [rv32_isa_pkg::XLEN-1:0]    fetch_pc,
    input  issue_pkg::decoded_t              decoded,
    input  logic                             rs1_conflict,
    input  logic                             rs2_conflict,
    input  issue_pkg::unit_mask_t            slot_free,
    output logic                             fetch_pop,
    output issue_pkg::unit_mask_t            unit_load,
    output logic                             illegal_valid,
    output logic [rv32_isa_pkg::XLEN-1:0]    illegal_pc
);

    import issue_pkg::*;

    logic operands_ready;
    logic slots_ready;
    logic issue_ok;
    logic take_illegal;

    ////////////////////////////////////////
    // Issue decision

    // Conflicts only matter on sources the instruction reads
    assign operands_ready = ~(decoded.uses_rs1 & rs1_conflict)
                          & ~(decoded.uses_rs2 & rs2_conflict);

    // Units not requested count as ready
    assign slots_ready = &(slot_free | ~decoded.unit_req);

    assign issue_ok = fetch_valid & decoded.legal & operands_ready & slots_ready;
    assign take_illegal = fetch_valid & ~decoded.legal;

    assign fetch_pop = issue_ok | take_illegal;
    assign unit_load = decoded.unit_req & {NUM_UNITS{issue_ok}};

    ////////////////////////////////////////
    // Illegal report

    always_ff @(posedge clk) begin
        if (rst) begin
            illegal_valid <= 1'b0;
        end else begin
            illegal_valid <= take_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (take_illegal) begin
            illegal_pc <= fetch_pc;
        end
    end

endmodule

/* src/operand_builder.sv */
////////////////////////////////////////
// Combinational; register data must match the instruction
////////////////////////////////////////

`timescale 1ns/1ps

module operand_builder (
    input  issue_pkg::fetch_packet_t  fetch,
    input  issue_pkg::rf_read_rsp_t   rf_rsp,
    output issue_pkg::alu_inputs_t    alu_inputs,
    output issue_pkg::ls_inputs_t     ls_inputs,
    output issue_pkg::branch_inputs_t branch_inputs
);

    import rv32_isa_pkg::*;
    import issue_pkg::*;

    opcode_t         opcode;
    fn3_t            fn3;
    reg_addr_t       rd_addr;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic            is_store;

    assign opcode = get_opcode(fetch.instruction);
    assign fn3 = get_fn3(fetch.instruction);
    assign rd_addr = fetch.instruction[11:7];

    ////////////////////////////////////////
    // ALU operands

    always_comb begin
        case (opcode)
            LUI:              alu_a = '0;
            AUIPC, JAL, JALR: alu_a = fetch.pc;
            default:          alu_a = rf_rsp.rs1_data;
        endcase

        case (opcode)
            LUI, AUIPC: alu_b = imm_u(fetch.instruction);
            ARITH_IMM:  alu_b = imm_i(fetch.instruction);
            JAL, JALR:  alu_b = XLEN'(4);
            default:    alu_b = rf_rsp.rs2_data;
        endcase
    end

    // fn3[0] set means unsigned compare, so no sign extension
    assign alu_inputs.in1 = {alu_a[XLEN-1] & ~fn3[0], alu_a};
    assign alu_inputs.in2 = {alu_b[XLEN-1] & ~fn3[0], alu_b};
    assign alu_inputs.fn3 = fn3;
    assign alu_inputs.alt = fetch.instruction[30];
    assign alu_inputs.rd_addr = rd_addr;

    ////////////////////////////////////////
    // Load-store

    assign is_store = (opcode == STORE);

    assign ls_inputs.address = rf_rsp.rs1_data
                             + (is_store ? imm_s(fetch.instruction)
                                         : imm_i(fetch.instruction));
    assign ls_inputs.store_data = rf_rsp.rs2_data;
    assign ls_inputs.fn3 = fn3;
    assign ls_inputs.is_load = (opcode == LOAD);
    assign ls_inputs.is_store = is_store;
    assign ls_inputs.rd_addr = rd_addr;

    ////////////////////////////////////////
    // Branch

    always_comb begin
        case (opcode)
            JAL:     branch_inputs.target_offset = imm_j(fetch.instruction);
            JALR:    branch_inputs.target_offset = imm_i(fetch.instruction);
            default: branch_inputs.target_offset = imm_b(fetch.instruction);
        endcase
    end

    assign branch_inputs.rs1 = rf_rsp.rs1_data;
    assign branch_inputs.rs2 = rf_rsp.rs2_data;
    assign branch_inputs.pc = fetch.pc;
    assign branch_inputs.fn3 = fn3;
    assign branch_inputs.use_signed = !(fn3 inside {BLTU_FN3, BGEU_FN3});
    assign branch_inputs.jal = (opcode == JAL);
    assign branch_inputs.jalr = (opcode == JALR);

endmodule

/* src/issue_slot.sv */
////////////////////////////////////////
// One entry; load only while free is high
////////////////////////////////////////

`timescale 1ns/1ps

module issue_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  payload_t payload_in,
    output logic     valid,
    output payload_t payload,
    input  logic     ready,
    output logic     free
);

    // Entry drains this cycle if the unit accepts it
    assign free = ~valid | ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    // Payload held through back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            payload <= payload_in;
        end
    end

endmodule

/* src/decode_issue.sv */
////////////////////////////////////////
// Register file answers rf_req in the same cycle
// Fetch must hold its packet until popped
////////////////////////////////////////

`timescale 1ns/1ps

module decode_issue (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fetch_valid,
    input  issue_pkg::fetch_packet_t       fetch,
    output logic                           fetch_pop,
    output issue_pkg::rf_read_req_t        rf_req,
    input  issue_pkg::rf_read_rsp_t        rf_rsp,
    output logic                           alu_valid,
    output issue_pkg::alu_inputs_t         alu_op,
    input  logic                           alu_ready,
    output logic                           ls_valid,
    output issue_pkg::ls_inputs_t          ls_op,
    input  logic                           ls_ready,
    output logic                           branch_valid,
    output issue_pkg::branch_inputs_t      branch_op,
    input  logic                           branch_ready,
    output logic                           illegal_valid,
    output logic [rv32_isa_pkg::XLEN-1:0]  illegal_pc
);

    import issue_pkg::*;

    decoded_t       decoded;
    unit_mask_t     slot_free;
    unit_mask_t     unit_load;
    alu_inputs_t    alu_inputs;
    ls_inputs_t     ls_inputs;
    branch_inputs_t branch_inputs;

    assign rf_req.rs1_addr = fetch.instruction[19:15];
    assign rf_req.rs2_addr = fetch.instruction[24:20];

    instr_classifier instr_classifier_i (
        .fetch   (fetch),
        .decoded (decoded)
    );

    issue_control issue_control_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch.pc),
        .decoded       (decoded),
        .rs1_conflict  (rf_rsp.rs1_conflict),
        .rs2_conflict  (rf_rsp.rs2_conflict),
        .slot_free     (slot_free),
        .fetch_pop     (fetch_pop),
        .unit_load     (unit_load),
        .illegal_valid (illegal_valid),
        .illegal_pc    (illegal_pc)
    );

    operand_builder operand_builder_i (
        .fetch         (fetch),
        .rf_rsp        (rf_rsp),
        .alu_inputs    (alu_inputs),
        .ls_inputs     (ls_inputs),
        .branch_inputs (branch_inputs)
    );

    ////////////////////////////////////////
    // Output slots, one per unit

    issue_slot #(.payload_t(alu_inputs_t)) alu_slot_i (
        .clk        (clk),
        .rst        (rst),
        .load       (unit_load[ALU_UNIT]),
        .payload_in (alu_inputs),
        .valid      (alu_valid),
        .payload    (alu_op),
        .ready      (alu_ready),
        .free       (slot_free[ALU_UNIT])
    );

    issue_slot #(.payload_t(ls_inputs_t)) ls_slot_i (
        .clk        (clk),
        .rst        (rst),
        .load       (unit_load[LS_UNIT]),
        .payload_in (ls_inputs),
        .valid      (ls_valid),
        .payload    (ls_op),
        .ready      (ls_ready),
        .free       (slot_free[LS_UNIT])
    );

    issue_slot #(.payload_t(branch_inputs_t)) branch_slot_i (
        .clk        (clk),
        .rst        (rst),
        .load       (unit_load[BRANCH_UNIT]),
        .payload_in (branch_inputs),
        .valid      (branch_valid),
        .payload    (branch_op),
        .ready      (branch_ready),
        .free       (slot_free[BRANCH_UNIT])
    );

endmodule

/* testbench/decode_issue_ref.svh */
////////////////////////////////////////
// Expected decode results from RV32I encoding rules
// Include inside a module that imports both packages
////////////////////////////////////////

`ifndef DECODE_ISSUE_REF_SVH
`define DECODE_ISSUE_REF_SVH

function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
    return {{(XLEN-12){v[11]}}, v};
endfunction

// Unit requests, source usage and legality
function automatic decoded_t ref_decode(input logic [31:0] instr);
    decoded_t   d;
    logic [6:0] op;
    op = instr[6:0];
    d = '0;
    d.legal = (op inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, ARITH_IMM})
              || (op == ARITH && !instr[25]);
    if (d.legal) begin
        d.unit_req[ALU_UNIT] = op inside {LUI, AUIPC, ARITH, ARITH_IMM, JAL, JALR};
        d.unit_req[LS_UNIT] = op inside {LOAD, STORE};
        d.unit_req[BRANCH_UNIT] = op inside {BRANCH, JAL, JALR};
        d.uses_rs1 = !(op inside {LUI, AUIPC, JAL});
        d.uses_rs2 = op inside {ARITH, STORE, BRANCH};
    end
    return d;
endfunction

function automatic alu_inputs_t ref_alu(input logic [31:0] pc, input logic [31:0] instr,
                                        input logic [31:0] rs1, input logic [31:0] rs2);
    alu_inputs_t     a;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    x = rs1;
    y = rs2;
    if (instr[6:0] == LUI) x = '0;
    if (instr[6:0] inside {AUIPC, JAL, JALR}) x = pc;
    if (instr[6:0] inside {LUI, AUIPC}) y = {instr[31:12], 12'h000};
    if (instr[6:0] == ARITH_IMM) y = sext12(instr[31:20]);
    if (instr[6:0] inside {JAL, JALR}) y = 32'd4;
    // Unsigned forms get a zero extension bit
    a.in1 = {x[XLEN-1] & !instr[12], x};
    a.in2 = {y[XLEN-1] & !instr[12], y};
    a.fn3 = instr[14:12];
    a.alt = instr[30];
    a.rd_addr = instr[11:7];
    return a;
endfunction

function automatic ls_inputs_t ref_ls(input logic [31:0] instr,
                                      input logic [31:0] rs1, input logic [31:0] rs2);
    ls_inputs_t l;
    if (instr[6:0] == STORE) begin
        l.address = rs1 + sext12({instr[31:25], instr[11:7]});
    end else begin
        l.address = rs1 + sext12(instr[31:20]);
    end
    l.store_data = rs2;
    l.fn3 = instr[14:12];
    l.is_load = (instr[6:0] == LOAD);
    l.is_store = (instr[6:0] == STORE);
    l.rd_addr = instr[11:7];
    return l;
endfunction

function automatic branch_inputs_t ref_branch(input logic [31:0] pc, input logic [31:0] instr,
                                              input logic [31:0] rs1, input logic [31:0] rs2);
    branch_inputs_t b;
    b.rs1 = rs1;
    b.rs2 = rs2;
    b.pc = pc;
    case (instr[6:0])
        JAL: b.target_offset = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        JALR: b.target_offset = sext12(instr[31:20]);
        default: b.target_offset = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    endcase
    b.fn3 = instr[14:12];
    // BLTU is 110 and BGEU is 111
    b.use_signed = (instr[14:13] != 2'b11);
    b.jal = (instr[6:0] == JAL);
    b.jalr = (instr[6:0] == JALR);
    return b;
endfunction

`endif

/* testbench/tb_decode_issue.sv */
////////////////////////////////////////
// Random RV32I stream, random conflicts and unit stalls
// Checks sampled on the falling edge
////////////////////////////////////////

`timescale 1ns/1ps

module tb_decode_issue;

    import rv32_isa_pkg::*;
    import issue_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int TEST_COUNT = 300;
    localparam int MAX_CYCLES = TEST_COUNT * 30;

    `include "decode_issue_ref.svh"

    logic            clk;
    logic            rst;
    logic            fetch_valid;
    fetch_packet_t   fetch;
    logic            fetch_pop;
    rf_read_req_t    rf_req;
    rf_read_rsp_t    rf_rsp;
    logic            alu_valid;
    alu_inputs_t     alu_op;
    logic            ls_valid;
    ls_inputs_t      ls_op;
    logic            branch_valid;
    branch_inputs_t  branch_op;
    logic            alu_ready, ls_ready, branch_ready;
    logic            illegal_valid;
    logic [XLEN-1:0] illegal_pc;

    // Register file model
    logic [XLEN-1:0] regs [32];
    logic            rs1_busy, rs2_busy;
    integer          seed;

    // Expected packets per unit, with the test index of each
    alu_inputs_t     alu_q[$];
    ls_inputs_t      ls_q[$];
    branch_inputs_t  branch_q[$];
    logic [XLEN-1:0] illegal_q[$];
    int              alu_idx_q[$], ls_idx_q[$], branch_idx_q[$], illegal_idx_q[$];

    int              pending [TEST_COUNT];
    bit              test_bad [TEST_COUNT];
    logic [XLEN-1:0] test_pc [TEST_COUNT];
    int              sent = 0;
    int              passed = 0;
    int              failed = 0;
    int              errors = 0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    decode_issue decode_issue_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .fetch         (fetch),
        .fetch_pop     (fetch_pop),
        .rf_req        (rf_req),
        .rf_rsp        (rf_rsp),
        .alu_valid     (alu_valid),
        .alu_op        (alu_op),
        .alu_ready     (alu_ready),
        .ls_valid      (ls_valid),
        .ls_op         (ls_op),
        .ls_ready      (ls_ready),
        .branch_valid  (branch_valid),
        .branch_op     (branch_op),
        .branch_ready  (branch_ready),
        .illegal_valid (illegal_valid),
        .illegal_pc    (illegal_pc)
    );

    always_comb begin
        rf_rsp.rs1_data = regs[rf_req.rs1_addr];
        rf_rsp.rs2_data = regs[rf_req.rs2_addr];
        rf_rsp.rs1_conflict = rs1_busy;
        rf_rsp.rs2_conflict = rs2_busy;
    end

    ////////////////////////////////////////
    // Checks and bookkeeping

    task automatic mark_error(input int idx);
        errors++;
        if (idx >= 0) test_bad[idx] = 1'b1;
    endtask

    task automatic check_flag(input int idx, input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
            mark_error(idx);
        end
    endtask

    task automatic check_alu(input int idx, input alu_inputs_t got, input alu_inputs_t exp);
        if (got !== exp) begin
            $display("Error at %0t: alu_op got %h expected %h", $time, got, exp);
            mark_error(idx);
        end
    endtask

    task automatic check_ls(input int idx, input ls_inputs_t got, input ls_inputs_t exp);
        if (got !== exp) begin
            $display("Error at %0t: ls_op got %h expected %h", $time, got, exp);
            mark_error(idx);
        end
    endtask

    task automatic check_branch(input int idx, input branch_inputs_t got,
                                input branch_inputs_t exp);
        if (got !== exp) begin
            $display("Error at %0t: branch_op got %h expected %h", $time, got, exp);
            mark_error(idx);
        end
    endtask

    task automatic check_illegal(input int idx, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: illegal_pc got %h expected %h", $time, got, exp);
            mark_error(idx);
        end
    endtask

    // One line per test once all its packets are seen
    task automatic finish_part(input int idx);
        pending[idx] = pending[idx] - 1;
        if (pending[idx] == 0) begin
            if (test_bad[idx]) begin
                failed++;
                $display("Test %0d pc %h: mismatch", idx, test_pc[idx]);
            end else begin
                passed++;
                $display("Test %0d pc %h: ok", idx, test_pc[idx]);
            end
        end
    endtask

    task automatic record_issue(input int idx);
        decoded_t        dec;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        dec = ref_decode(fetch.instruction);
        rs1 = regs[fetch.instruction[19:15]];
        rs2 = regs[fetch.instruction[24:20]];
        test_pc[idx] = fetch.pc;
        pending[idx] = 0;
        if (!dec.legal) begin
            illegal_q.push_back(fetch.pc);
            illegal_idx_q.push_back(idx);
            pending[idx] = 1;
        end
        if (dec.unit_req[ALU_UNIT]) begin
            alu_q.push_back(ref_alu(fetch.pc, fetch.instruction, rs1, rs2));
            alu_idx_q.push_back(idx);
            pending[idx]++;
        end
        if (dec.unit_req[LS_UNIT]) begin
            ls_q.push_back(ref_ls(fetch.instruction, rs1, rs2));
            ls_idx_q.push_back(idx);
            pending[idx]++;
        end
        if (dec.unit_req[BRANCH_UNIT]) begin
            branch_q.push_back(ref_branch(fetch.pc, fetch.instruction, rs1, rs2));
            branch_idx_q.push_back(idx);
            pending[idx]++;
        end
    endtask

    ////////////////////////////////////////
    // Compare process

    // Queue depth at the falling edge equals slot occupancy
    always @(negedge clk) begin : compare
        decoded_t       dec;
        logic           exp_pop;
        logic           alu_free, ls_free, branch_free;
        if (!rst) begin
            check_flag(-1, "alu_valid", alu_valid, alu_q.size() != 0);
            check_flag(-1, "ls_valid", ls_valid, ls_q.size() != 0);
            check_flag(-1, "branch_valid", branch_valid, branch_q.size() != 0);
            check_flag(-1, "illegal_valid", illegal_valid, illegal_q.size() != 0);
            alu_free = (alu_q.size() == 0) || alu_ready;
            ls_free = (ls_q.size() == 0) || ls_ready;
            branch_free = (branch_q.size() == 0) || branch_ready;
            // No pop without a valid instruction
            exp_pop = 1'b0;
            if (fetch_valid) begin
                dec = ref_decode(fetch.instruction);
                exp_pop = !dec.legal
                    || (!(dec.uses_rs1 && rs1_busy) && !(dec.uses_rs2 && rs2_busy)
                        && (alu_free || !dec.unit_req[ALU_UNIT])
                        && (ls_free || !dec.unit_req[LS_UNIT])
                        && (branch_free || !dec.unit_req[BRANCH_UNIT]));
            end
            check_flag(fetch_valid ? sent : -1, "fetch_pop", fetch_pop, exp_pop);
            // Held payloads are compared every cycle, popped on transfer
            if (alu_valid && alu_q.size() != 0) begin
                check_alu(alu_idx_q[0], alu_op, alu_q[0]);
                if (alu_ready) begin
                    void'(alu_q.pop_front());
                    finish_part(alu_idx_q.pop_front());
                end
            end
            if (ls_valid && ls_q.size() != 0) begin
                check_ls(ls_idx_q[0], ls_op, ls_q[0]);
                if (ls_ready) begin
                    void'(ls_q.pop_front());
                    finish_part(ls_idx_q.pop_front());
                end
            end
            if (branch_valid && branch_q.size() != 0) begin
                check_branch(branch_idx_q[0], branch_op, branch_q[0]);
                if (branch_ready) begin
                    void'(branch_q.pop_front());
                    finish_part(branch_idx_q.pop_front());
                end
            end
            if (illegal_valid && illegal_q.size() != 0) begin
                check_illegal(illegal_idx_q[0], illegal_pc, illegal_q[0]);
                void'(illegal_q.pop_front());
                finish_part(illegal_idx_q.pop_front());
            end
            if (fetch_valid && fetch_pop) record_issue(sent);
        end
    end

    ////////////////////////////////////////
    // Stimulus

    task automatic make_instr(output logic [31:0] instr);
        int pick;
        instr = $random(seed);
        pick = ($random(seed) & 32'h7fff_ffff) % 13;
        case (pick)
            0: instr[6:0] = LUI;
            1: instr[6:0] = AUIPC;
            2: instr[6:0] = JAL;
            3: instr[6:0] = JALR;
            4: instr[6:0] = BRANCH;
            5: instr[6:0] = LOAD;
            6: instr[6:0] = STORE;
            7: instr[6:0] = ARITH_IMM;
            8, 9: begin
                instr[6:0] = ARITH;
                instr[25] = 1'b0;
            end
            // FENCE, SYSTEM and MUL/DIV
            10: instr[6:0] = 7'b0001111;
            11: instr[6:0] = 7'b1110011;
            default: begin
                instr[6:0] = ARITH;
                instr[25] = 1'b1;
            end
        endcase
    endtask

    initial begin
        logic [31:0] instr;
        logic        took;
        logic [31:0] next_pc;
        seed = 32'ha8b9;
        next_pc = 32'h0000_1000;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch = '0;
        alu_ready = 1'b0;
        ls_ready = 1'b0;
        branch_ready = 1'b0;
        rs1_busy = 1'b0;
        rs2_busy = 1'b0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = $random(seed);
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        while (sent < TEST_COUNT) begin
            alu_ready = ($random(seed) & 7) > 2;
            ls_ready = ($random(seed) & 7) > 2;
            branch_ready = ($random(seed) & 7) > 2;
            rs1_busy = ($random(seed) & 3) == 0;
            rs2_busy = ($random(seed) & 3) == 0;
            // Occasional fetch bubble
            if (!fetch_valid && (($random(seed) & 3) != 0)) begin
                make_instr(instr);
                fetch.pc = next_pc;
                fetch.instruction = instr;
                next_pc = next_pc + 4;
                fetch_valid = 1'b1;
            end
            @(negedge clk);
            took = fetch_valid && fetch_pop;
            @(posedge clk);
            #2;
            if (took) begin
                fetch_valid = 1'b0;
                sent++;
            end
        end
        // Drain the slots
        alu_ready = 1'b1;
        ls_ready = 1'b1;
        branch_ready = 1'b1;
        rs1_busy = 1'b0;
        rs2_busy = 1'b0;
        while (alu_q.size() + ls_q.size() + branch_q.size() + illegal_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 TEST_COUNT, passed, failed, errors);
        if (errors == 0 && passed == TEST_COUNT) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * MAX_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* files.f */
+incdir+testbench
src/rv32_isa_pkg.sv
src/issue_pkg.sv
src/instr_classifier.sv
src/issue_control.sv
src/operand_builder.sv
src/issue_slot.sv
src/decode_issue.sv
testbench/tb_decode_issue.sv

/* Bender.yml */
package:
  name: decode_issue

sources:
  - src/rv32_isa_pkg.sv
  - src/issue_pkg.sv
  - src/instr_classifier.sv
  - src/issue_control.sv
  - src/operand_builder.sv
  - src/issue_slot.sv
  - src/decode_issue.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decode_issue.sv
